//--- src/sdram_pkg.sv
package sdram_pkg;

    // encoding is {ncs, nras, ncas, nwe}
    typedef enum logic [3:0] {
        LOAD_MODE = 4'b0000,
        REFRESH   = 4'b0001,
        PRECHARGE = 4'b0010,
        ACTIVE    = 4'b0011,
        WRITE     = 4'b0100,
        READ      = 4'b0101,
        NOP       = 4'b0111,
        INHIBIT   = 4'b1000
    } sdram_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        ACT,        // ACTIVE requested, waiting for grant
        WAIT_RCD,
        RW,         // READ/WRITE requested
        DATA,
        WAIT_PRE    // auto-precharge in progress
    } bank_state_e;

    // request address is {row, col}
    localparam int ADDR_W    = 22;
    localparam int ROW_W     = 13;
    localparam int COL_W     = 9;

    localparam int BURST_LEN = 4;
    localparam int CAS_LAT   = 2;

    // timing in clock cycles
    localparam int T_RCD     = 2;
    localparam int T_RP      = 2;
    localparam int T_RFC     = 7;
    localparam int T_WR_PRE  = 4;   // last write word to bank idle

    localparam int INIT_WAIT = 64;  // short power-up wait for simulation
    localparam int RFSH_CNT  = 2;

    // write burst mode, CL2, sequential, burst of 4
    localparam logic [ROW_W-1:0] MODE_WORD = 13'b000_0_00_010_0_010;

endpackage

//--- src/sdram_bank_if.sv
`timescale 1ns/10ps

interface sdram_bank_if;
    logic                          br;       // bus request
    sdram_pkg::sdram_cmd_e         cmd;
    logic [sdram_pkg::ROW_W-1:0]   a;
    logic                          rw_req;   // cmd needs the data bus
    logic                          wr_phase; // write word sampled this cycle
    logic                          bg;       // one-cycle grant
    logic                          bus_free;

    modport bank (
        output br,
        output cmd,
        output a,
        output rw_req,
        output wr_phase,
        input  bg,
        input  bus_free
    );

    modport arb (
        input  br,
        input  cmd,
        input  a,
        input  rw_req,
        input  wr_phase,
        output bg,
        output bus_free
    );
endinterface

//--- src/sdram_init.sv
`timescale 1ns/10ps

module sdram_init (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        init,
    output sdram_pkg::sdram_cmd_e       cmd,
    output logic [sdram_pkg::ROW_W-1:0] a
);
    logic [6:0] wait_cnt;
    logic [2:0] step;   // 0 power-up, 1-2 refresh, 3 load mode, 4 done

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init     <= 1'b1;
            cmd      <= sdram_pkg::NOP;
            a        <= '0;
            step     <= '0;
            wait_cnt <= 7'(sdram_pkg::INIT_WAIT - 1);
        end else begin
            cmd <= sdram_pkg::NOP;  // one cycle per command
            if (init) begin
                if (wait_cnt != 7'd0) begin
                    wait_cnt <= wait_cnt - 7'd1;
                end else begin
                    step <= step + 3'd1;
                    case (step)
                        3'd0: begin
                            cmd      <= sdram_pkg::PRECHARGE;
                            a        <= 13'h0400;   // A10 selects all banks
                            wait_cnt <= 7'(sdram_pkg::T_RP - 1);
                        end
                        3'd1, 3'd2: begin
                            cmd      <= sdram_pkg::REFRESH;
                            wait_cnt <= 7'(sdram_pkg::T_RFC - 1);
                        end
                        3'd3: begin
                            cmd      <= sdram_pkg::LOAD_MODE;
                            a        <= sdram_pkg::MODE_WORD;
                            wait_cnt <= 7'(sdram_pkg::T_RP - 1); // covers tMRD
                        end
                        default: init <= 1'b0;
                    endcase
                end
            end
        end
    end

endmodule

//--- src/sdram_rfsh.sv
`timescale 1ns/10ps

module sdram_rfsh (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        all_idle,
    output logic                        br,
    input  logic                        bg,
    output logic                        rfshing,
    output sdram_pkg::sdram_cmd_e       cmd,
    output logic [sdram_pkg::ROW_W-1:0] a
);
    logic       pending;
    logic [2:0] wait_cnt;
    logic [1:0] left;       // refreshes still to issue
    logic       issue;

    // only ask once every bank has closed its row
    assign br    = pending && all_idle && !rfshing;
    assign issue = bg || (rfshing && wait_cnt == 3'd0 && left != 2'd0);
    assign cmd   = issue ? sdram_pkg::REFRESH : sdram_pkg::NOP;
    assign a     = '0;      // refresh takes no address

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= 1'b0;
            rfshing  <= 1'b0;
            wait_cnt <= '0;
            left     <= '0;
        end else begin
            if (start) begin
                pending <= 1'b1;
            end else if (bg) begin
                pending <= 1'b0;
            end

            if (bg) begin
                rfshing  <= 1'b1;
                left     <= 2'(sdram_pkg::RFSH_CNT - 1);
                wait_cnt <= 3'(sdram_pkg::T_RFC - 1);
            end else if (rfshing) begin
                if (wait_cnt != 3'd0) begin
                    wait_cnt <= wait_cnt - 3'd1;
                end else if (left != 2'd0) begin
                    left     <= left - 2'd1;
                    wait_cnt <= 3'(sdram_pkg::T_RFC - 1);
                end else begin
                    rfshing <= 1'b0;    // tRFC of the last one is over
                end
            end
        end
    end

endmodule

//--- src/sdram_bank.sv
`timescale 1ns/10ps

module sdram_bank (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [sdram_pkg::ADDR_W-1:0] addr,
    input  logic                         rd,
    input  logic                         wr,
    input  logic                         hold,
    output logic                         ack,
    output logic                         dst,
    output logic                         dok,
    output logic                         rdy,
    output logic                         idle,
    sdram_bank_if.bank                   bus
);
    sdram_pkg::bank_state_e state;

    logic [sdram_pkg::ROW_W-1:0] row;
    logic [sdram_pkg::COL_W-1:0] col;
    logic                        we;
    logic [2:0]                  cnt;
    logic                        start;
    logic                        wr_first;
    logic                        in_data;

    assign start    = state == sdram_pkg::IDLE && (rd || wr) && !hold;
    assign in_data  = state == sdram_pkg::DATA;
    assign wr_first = state == sdram_pkg::RW && bus.bg && we;
    assign idle     = state == sdram_pkg::IDLE;
    assign ack      = state == sdram_pkg::ACT && bus.bg;

    // data window timed from the READ/WRITE grant, cnt is 0 on the cycle after it
    always_comb begin
        if (we) begin
            // word 0 is sampled in the grant cycle, it travels with WRITE
            dst = wr_first;
            dok = wr_first || (in_data && cnt < 3'(sdram_pkg::BURST_LEN - 1));
            rdy = in_data && cnt == 3'(sdram_pkg::BURST_LEN - 1);
        end else begin
            // CAS latency plus the dout register
            dst = in_data && cnt == 3'(sdram_pkg::CAS_LAT + 1);
            dok = in_data && cnt >= 3'(sdram_pkg::CAS_LAT + 1)
                          && cnt <= 3'(sdram_pkg::CAS_LAT + sdram_pkg::BURST_LEN);
            rdy = in_data && cnt == 3'(sdram_pkg::CAS_LAT + sdram_pkg::BURST_LEN + 1);
        end
    end

    assign bus.br       = state == sdram_pkg::ACT || state == sdram_pkg::RW;
    assign bus.rw_req   = state == sdram_pkg::RW;
    assign bus.wr_phase = we && dok;

    always_comb begin
        case (state)
            sdram_pkg::ACT: begin
                bus.cmd = sdram_pkg::ACTIVE;
                bus.a   = row;
            end
            sdram_pkg::RW: begin
                bus.cmd = we ? sdram_pkg::WRITE : sdram_pkg::READ;
                bus.a   = {2'b00, 1'b1, 1'b0, col};    // A10 for auto-precharge
            end
            default: begin
                bus.cmd = sdram_pkg::NOP;
                bus.a   = '0;
            end
        endcase
    end

    // request is registered here, the requester holds it until ack anyway
    always_ff @(posedge clk) begin
        if (start) begin
            row <= addr[sdram_pkg::ADDR_W-1:sdram_pkg::COL_W];
            col <= addr[sdram_pkg::COL_W-1:0];
            we  <= wr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sdram_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                sdram_pkg::IDLE: begin
                    if (start) state <= sdram_pkg::ACT;
                end
                sdram_pkg::ACT: begin
                    if (bus.bg) begin
                        state <= sdram_pkg::WAIT_RCD;
                        cnt   <= 3'(sdram_pkg::T_RCD - 1);
                    end
                end
                sdram_pkg::WAIT_RCD: begin
                    cnt <= cnt - 3'd1;
                    if (cnt <= 3'd1) state <= sdram_pkg::RW;   // READ lands tRCD after ACTIVE
                end
                sdram_pkg::RW: begin
                    if (bus.bg) begin
                        state <= sdram_pkg::DATA;
                        cnt   <= '0;
                    end
                end
                sdram_pkg::DATA: begin
                    cnt <= cnt + 3'd1;
                    if (rdy) begin
                        state <= sdram_pkg::WAIT_PRE;
                        cnt   <= we ? 3'(sdram_pkg::T_WR_PRE - 1) : 3'(sdram_pkg::T_RP - 1);
                    end
                end
                sdram_pkg::WAIT_PRE: begin
                    cnt <= cnt - 3'd1;
                    if (cnt == 3'd0) state <= sdram_pkg::IDLE;
                end
                default: state <= sdram_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- src/sdram_cmd_arbiter.sv
`timescale 1ns/10ps

module sdram_cmd_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        init,
    input  sdram_pkg::sdram_cmd_e       init_cmd,
    input  logic [sdram_pkg::ROW_W-1:0] init_a,
    input  logic                        rfsh_br,
    output logic                        rfsh_bg,
    input  logic                        rfshing,
    input  sdram_pkg::sdram_cmd_e       rfsh_cmd,
    input  logic [sdram_pkg::ROW_W-1:0] rfsh_a,
    sdram_bank_if.arb                   banks [4],
    input  logic [15:0]                 din,
    input  logic [1:0]                  din_m,
    output logic [15:0]                 dout,
    output logic [sdram_pkg::ROW_W-1:0] sdram_a,
    output logic [1:0]                  sdram_ba,
    output sdram_pkg::sdram_cmd_e       sdram_cmd,
    output logic [1:0]                  sdram_dqm,
    inout  wire  [15:0]                 sdram_dq
);
    logic [3:0]                  br;
    logic [3:0]                  rw_req;
    logic [3:0]                  wr_phase;
    logic [3:0]                  bg;
    logic [3:0]                  eligible;
    sdram_pkg::sdram_cmd_e       bank_cmd [4];
    logic [sdram_pkg::ROW_W-1:0] bank_a [4];

    logic [14:0]                 lfsr;
    logic [1:0]                  idx;
    logic [2:0]                  bus_cnt;   // cycles until the data window is free
    logic                        bus_free;
    sdram_pkg::sdram_cmd_e       next_cmd;
    logic [sdram_pkg::ROW_W-1:0] next_a;
    logic [1:0]                  next_ba;
    logic                        dq_oe;
    logic [15:0]                 dq_out;

    for (genvar i = 0; i < 4; i++) begin : g_bank
        assign br[i]             = banks[i].br;
        assign rw_req[i]         = banks[i].rw_req;
        assign wr_phase[i]       = banks[i].wr_phase;
        assign bank_cmd[i]       = banks[i].cmd;
        assign bank_a[i]         = banks[i].a;
        assign banks[i].bg       = bg[i];
        assign banks[i].bus_free = bus_free;
    end

    assign bus_free = bus_cnt == 3'd0;
    assign eligible = br & ~(rw_req & {4{~bus_free}});
    assign rfsh_bg  = rfsh_br && !init;

    // rotating search from the lfsr start index
    always_comb begin
        bg  = '0;
        idx = lfsr[1:0];
        if (!init && !rfsh_br && !rfshing) begin
            for (int k = 3; k >= 0; k--) begin
                idx = lfsr[1:0] + 2'(k);
                if (eligible[idx]) bg = 4'b0001 << idx;   // lowest offset wins
            end
        end
    end

    always_comb begin
        next_cmd = sdram_pkg::NOP;
        next_a   = '0;
        next_ba  = '0;
        if (init) begin
            next_cmd = init_cmd;
            next_a   = init_a;
        end else if (rfsh_bg || rfshing) begin
            next_cmd = rfsh_cmd;
            next_a   = rfsh_a;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (bg[i]) begin
                    next_cmd = bank_cmd[i];
                    next_a   = bank_a[i];
                    next_ba  = 2'(i);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr      <= 15'd1;
            bus_cnt   <= '0;
            sdram_cmd <= sdram_pkg::NOP;
            sdram_dqm <= '0;
            dq_oe     <= 1'b0;
        end else begin
            lfsr <= {lfsr[13:0], lfsr[14] ^ lfsr[13]};
            if (|(bg & rw_req)) begin
                // reads also leave room for the bus turnaround
                bus_cnt <= (next_cmd == sdram_pkg::READ) ?
                           3'(sdram_pkg::BURST_LEN + sdram_pkg::CAS_LAT) :
                           3'(sdram_pkg::BURST_LEN - 1);
            end else if (!bus_free) begin
                bus_cnt <= bus_cnt - 3'd1;
            end
            sdram_cmd <= next_cmd;
            dq_oe     <= |wr_phase;
            sdram_dqm <= |wr_phase ? din_m : 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        sdram_a  <= next_a;
        sdram_ba <= next_ba;
        dq_out   <= din;
        dout     <= sdram_dq;
    end

    assign sdram_dq = dq_oe ? dq_out : 16'hzzzz;

endmodule

//--- src/sdram_ctrl.sv
`timescale 1ns/10ps

module sdram_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         init,
    input  logic                         rfsh,      // e.g. video blanking
    input  logic [sdram_pkg::ADDR_W-1:0] ba0_addr,
    input  logic [sdram_pkg::ADDR_W-1:0] ba1_addr,
    input  logic [sdram_pkg::ADDR_W-1:0] ba2_addr,
    input  logic [sdram_pkg::ADDR_W-1:0] ba3_addr,
    input  logic [3:0]                   rd,
    input  logic [3:0]                   wr,
    input  logic [15:0]                  din,
    input  logic [1:0]                   din_m,
    output logic [3:0]                   ack,
    output logic [3:0]                   dst,
    output logic [3:0]                   dok,
    output logic [3:0]                   rdy,
    output logic [15:0]                  dout,
    inout  wire  [15:0]                  sdram_dq,
    output logic [sdram_pkg::ROW_W-1:0]  sdram_a,
    output logic [1:0]                   sdram_ba,
    output logic                         sdram_nwe,
    output logic                         sdram_ncas,
    output logic                         sdram_nras,
    output logic                         sdram_ncs,
    output logic                         sdram_dqml,
    output logic                         sdram_dqmh,
    output logic                         sdram_cke
);
    sdram_pkg::sdram_cmd_e       init_cmd;
    logic [sdram_pkg::ROW_W-1:0] init_a;
    logic                        rfsh_br;
    logic                        rfsh_bg;
    logic                        rfshing;
    sdram_pkg::sdram_cmd_e       rfsh_cmd;
    logic [sdram_pkg::ROW_W-1:0] rfsh_a;
    logic [3:0]                  idle;
    logic                        hold;
    sdram_pkg::sdram_cmd_e       cmd;
    logic [1:0]                  dqm;
    logic [sdram_pkg::ADDR_W-1:0] addr [4];

    sdram_bank_if bank_bus [4] ();

    assign addr[0] = ba0_addr;
    assign addr[1] = ba1_addr;
    assign addr[2] = ba2_addr;
    assign addr[3] = ba3_addr;

    // banks take no new request while init or refresh owns the chip
    assign hold = init || rfsh_br || rfshing;

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
    assign {sdram_dqmh, sdram_dqml} = dqm;
    assign sdram_cke = 1'b1;

    sdram_init u_init (
        .clk  (clk),
        .rst  (rst),
        .init (init),
        .cmd  (init_cmd),
        .a    (init_a)
    );

    sdram_rfsh u_rfsh (
        .clk      (clk),
        .rst      (rst),
        .start    (rfsh),
        .all_idle (&idle),
        .br       (rfsh_br),
        .bg       (rfsh_bg),
        .rfshing  (rfshing),
        .cmd      (rfsh_cmd),
        .a        (rfsh_a)
    );

    for (genvar i = 0; i < 4; i++) begin : g_bank
        sdram_bank u_bank (
            .clk  (clk),
            .rst  (rst),
            .addr (addr[i]),
            .rd   (rd[i]),
            .wr   (wr[i]),
            .hold (hold),
            .ack  (ack[i]),
            .dst  (dst[i]),
            .dok  (dok[i]),
            .rdy  (rdy[i]),
            .idle (idle[i]),
            .bus  (bank_bus[i])
        );
    end

    sdram_cmd_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .init      (init),
        .init_cmd  (init_cmd),
        .init_a    (init_a),
        .rfsh_br   (rfsh_br),
        .rfsh_bg   (rfsh_bg),
        .rfshing   (rfshing),
        .rfsh_cmd  (rfsh_cmd),
        .rfsh_a    (rfsh_a),
        .banks     (bank_bus),
        .din       (din),
        .din_m     (din_m),
        .dout      (dout),
        .sdram_a   (sdram_a),
        .sdram_ba  (sdram_ba),
        .sdram_cmd (cmd),
        .sdram_dqm (dqm),
        .sdram_dq  (sdram_dq)
    );

endmodule

//--- verif/sdram_chip_model.sv
`timescale 1ns/10ps

module sdram_chip_model (
    input  logic        clk,
    inout  wire  [15:0] dq,
    input  logic [12:0] a,
    input  logic [1:0]  ba,
    input  logic        ncs,
    input  logic        nras,
    input  logic        ncas,
    input  logic        nwe,
    input  logic        dqml,
    input  logic        dqmh,
    input  logic        cke,
    output logic        init_ok,    // init sequence seen in order
    output int          rfsh_count
);
    logic [15:0] mem [int unsigned];
    logic [12:0] open_row [4];
    logic [15:0] rd_data [5];
    logic        rd_valid [5];      // slot 0 drives dq this cycle
    logic [3:0]  cmd;
    logic [1:0]  wr_left;
    logic [1:0]  wr_ba;
    logic [8:0]  wr_col;
    int          seq;               // 0 precharge-all, 1-2 refresh, 3 load mode, 4 done

    assign cmd     = {ncs, nras, ncas, nwe};
    assign init_ok = seq == 4;
    assign dq      = rd_valid[0] ? rd_data[0] : 16'hzzzz;

    function automatic int unsigned mem_key(logic [1:0] b, logic [12:0] r, logic [8:0] c);
        return {8'h00, b, r, c};
    endfunction

    task automatic store(int unsigned k, logic [15:0] d, logic [1:0] m);
        logic [15:0] old;
        old = mem.exists(k) ? mem[k] : 16'h0000;
        mem[k] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endtask

    initial begin
        seq        = 0;
        rfsh_count = 0;
        wr_left    = '0;
        for (int i = 0; i < 5; i++) begin
            rd_valid[i] = 1'b0;
            rd_data[i]  = '0;
        end
    end

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            rd_valid[i] <= rd_valid[i+1];
            rd_data[i]  <= rd_data[i+1];
        end
        rd_valid[4] <= 1'b0;
        if (wr_left != 2'd0) begin      // write burst continues
            store(mem_key(wr_ba, open_row[wr_ba], wr_col), dq, {dqmh, dqml});
            wr_col  <= wr_col + 9'd1;
            wr_left <= wr_left - 2'd1;
        end
        if (cke) begin
            case (cmd)
                sdram_pkg::ACTIVE: open_row[ba] <= a;
                sdram_pkg::READ: begin
                    for (int k = 0; k < 4; k++) begin   // CL2 lands in slots 1..4
                        rd_valid[k+1] <= 1'b1;
                        rd_data[k+1]  <= mem.exists(mem_key(ba, open_row[ba], a[8:0] + 9'(k)))
                                       ? mem[mem_key(ba, open_row[ba], a[8:0] + 9'(k))]
                                       : 16'h0000;
                    end
                end
                sdram_pkg::WRITE: begin
                    store(mem_key(ba, open_row[ba], a[8:0]), dq, {dqmh, dqml});
                    wr_left <= 2'd3;
                    wr_ba   <= ba;
                    wr_col  <= a[8:0] + 9'd1;
                end
                sdram_pkg::REFRESH: begin
                    rfsh_count <= rfsh_count + 1;
                    if (seq == 1 || seq == 2) seq <= seq + 1;
                end
                sdram_pkg::PRECHARGE: if (seq == 0 && a[10]) seq <= 1;
                sdram_pkg::LOAD_MODE: if (seq == 3 && a == sdram_pkg::MODE_WORD) seq <= 4;
                default: ;
            endcase
        end
    end

endmodule

//--- verif/sdram_asserts.sv
`timescale 1ns/10ps

module sdram_asserts (
    input logic                  clk,
    input logic                  rst,
    input sdram_pkg::sdram_cmd_e sdram_cmd,
    input logic                  dq_oe,
    input logic                  rfshing
);
    logic rd_cmd;
    logic wr_cmd;
    logic rw_cmd;   // column command on the pins

    assign rd_cmd = sdram_cmd == sdram_pkg::READ;
    assign wr_cmd = sdram_cmd == sdram_pkg::WRITE;
    assign rw_cmd = rd_cmd || wr_cmd;

    // a burst of four words keeps the next column command away
    burst_overlap: assert property (@(posedge clk) disable iff (rst)
        rw_cmd |-> !($past(rw_cmd, 1) || $past(rw_cmd, 2) || $past(rw_cmd, 3)))
        else $error("column command inside the previous burst");

    // read words come back CAS_LAT late
    wr_after_rd: assert property (@(posedge clk) disable iff (rst)
        wr_cmd |-> !($past(rd_cmd, 1) || $past(rd_cmd, 2) || $past(rd_cmd, 3)
                     || $past(rd_cmd, 4) || $past(rd_cmd, 5)))
        else $error("write burst collides with returning read data");

    no_cmd_in_rfsh: assert property (@(posedge clk) disable iff (rst)
        rfshing |=> (sdram_cmd == sdram_pkg::REFRESH || sdram_cmd == sdram_pkg::NOP))
        else $error("bank command issued during refresh");

    dq_drive_in_write: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> (wr_cmd || $past(wr_cmd, 1) || $past(wr_cmd, 2) || $past(wr_cmd, 3)))
        else $error("dq driven outside a write burst");
endmodule

bind sdram_cmd_arbiter sdram_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .sdram_cmd (sdram_cmd),
    .dq_oe     (dq_oe),
    .rfshing   (rfshing)
);

//--- verif/tb_sdram_ctrl.sv
`timescale 1ns/10ps

module tb_sdram_ctrl;
    localparam int N_TXN     = 8 + 12 + 32 + 200 + 100;
    localparam int MAX_CYCLE = N_TXN * 40 + 1000;  // plus init and refresh

    logic        clk;
    logic        rst;
    logic        rfsh;
    logic [21:0] port_addr [4];
    logic [3:0]  rd;
    logic [3:0]  wr;
    logic [15:0] din;
    logic [1:0]  din_m;
    logic        init;
    logic [3:0]  ack, dst, dok, rdy;
    logic [15:0] dout;
    wire  [15:0] sdram_dq;
    logic [12:0] sdram_a;
    logic [1:0]  sdram_ba;
    logic        sdram_nwe, sdram_ncas, sdram_nras, sdram_ncs;
    logic        sdram_dqml, sdram_dqmh, sdram_cke;
    logic        init_ok;
    int          rfsh_count;

    integer      seed = 93776;
    logic [15:0] mem_model [int unsigned];
    logic [22:0] req_q [4][$];      // {we, addr}
    logic [21:0] pool [4][8];
    int          st [4];            // 0 free, 1 wait ack, 2 data phase
    int          nword [4];
    logic        cur_we [4];
    logic [21:0] cur_addr [4];
    int          mask_mode;         // 0 none, 1 one byte, 2 sometimes
    logic        gate_on;
    int          errors, checks, cycles, test_err, base;

    sdram_ctrl uut (
        .clk (clk), .rst (rst), .init (init), .rfsh (rfsh),
        .ba0_addr (port_addr[0]), .ba1_addr (port_addr[1]),
        .ba2_addr (port_addr[2]), .ba3_addr (port_addr[3]),
        .rd (rd), .wr (wr), .din (din), .din_m (din_m),
        .ack (ack), .dst (dst), .dok (dok), .rdy (rdy), .dout (dout),
        .sdram_dq (sdram_dq), .sdram_a (sdram_a), .sdram_ba (sdram_ba),
        .sdram_nwe (sdram_nwe), .sdram_ncas (sdram_ncas), .sdram_nras (sdram_nras),
        .sdram_ncs (sdram_ncs), .sdram_dqml (sdram_dqml), .sdram_dqmh (sdram_dqmh),
        .sdram_cke (sdram_cke)
    );

    sdram_chip_model u_chip (
        .clk (clk), .dq (sdram_dq), .a (sdram_a), .ba (sdram_ba),
        .ncs (sdram_ncs), .nras (sdram_nras), .ncas (sdram_ncas), .nwe (sdram_nwe),
        .dqml (sdram_dqml), .dqmh (sdram_dqmh), .cke (sdram_cke),
        .init_ok (init_ok), .rfsh_count (rfsh_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned ref_key(int p, logic [21:0] ad, int k);
        return {8'h00, 2'(p), ad[21:2], 2'(k)};
    endfunction

    function automatic logic all_done();
        for (int i = 0; i < 4; i++) begin
            if (req_q[i].size() != 0 || st[i] != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic drain();
        while (!all_done()) @(posedge clk);
    endtask

    task automatic report(string name);
        $display("%s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // request ports, write data capture and read checks
    always @(posedge clk) begin
        logic [15:0] old;
        logic [15:0] exp;
        din <= 16'($random(seed));
        case (mask_mode)
            1: din_m <= ($random(seed) & 1) ? 2'b01 : 2'b10;
            2: din_m <= (($random(seed) & 3) == 0) ? 2'($random(seed)) : 2'b00;
            default: din_m <= 2'b00;
        endcase
        for (int i = 0; i < 4; i++) begin
            assert (!(ack[i] && st[i] != 1)) else begin
                $display("port %0d acknowledged with no request waiting", i);
                errors++;
            end
            assert (!((dst[i] || dok[i] || rdy[i]) && st[i] != 2)) else begin
                $display("port %0d data strobe outside its data phase", i);
                errors++;
            end
            if (st[i] == 1 && ack[i]) begin
                rd[i]    <= 1'b0;
                wr[i]    <= 1'b0;
                st[i]    = 2;
                nword[i] = 0;
            end else if (st[i] == 2) begin
                assert (dst[i] == (dok[i] && nword[i] == 0)) else begin
                    $display("[ERROR] %0t dst[%0d]: expected %0b, got %0b",
                             $time, i, dok[i] && nword[i] == 0, dst[i]);
                    errors++;
                end
                if (dok[i]) begin
                    checks++;
                    if (cur_we[i]) begin
                        old = mem_model.exists(ref_key(i, cur_addr[i], nword[i])) ?
                              mem_model[ref_key(i, cur_addr[i], nword[i])] : 16'h0000;
                        mem_model[ref_key(i, cur_addr[i], nword[i])] =
                            {din_m[1] ? old[15:8] : din[15:8], din_m[0] ? old[7:0] : din[7:0]};
                    end else begin
                        exp = mem_model.exists(ref_key(i, cur_addr[i], nword[i])) ?
                              mem_model[ref_key(i, cur_addr[i], nword[i])] : 16'hxxxx;
                        assert (dout === exp) else begin
                            $display("[ERROR] %0t dout port %0d word %0d: expected %h, got %h",
                                     $time, i, nword[i], exp, dout);
                            errors++;
                        end
                    end
                    nword[i]++;
                end
                if (rdy[i]) begin
                    checks++;
                    assert (nword[i] == 4) else begin
                        $display("[ERROR] %0t dok[%0d] count: expected 4, got %0d",
                                 $time, i, nword[i]);
                        errors++;
                    end
                    st[i] = 0;
                end
            end
            if (st[i] == 0 && req_q[i].size() != 0 && (!gate_on || ($random(seed) & 1))) begin
                {cur_we[i], cur_addr[i]} = req_q[i].pop_front();
                port_addr[i] <= cur_addr[i];
                rd[i]        <= !cur_we[i];
                wr[i]        <= cur_we[i];
                st[i]        = 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLE) begin
            $display("timeout after %0d cycles, requests did not complete", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int p;
        rst = 1'b1;
        rfsh = 1'b0;
        rd = '0;
        wr = '0;
        din = '0;
        din_m = '0;
        mask_mode = 0;
        gate_on = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        test_err = 0;
        for (int i = 0; i < 4; i++) begin
            port_addr[i] = '0;
            st[i] = 0;
            for (int j = 0; j < 8; j++) begin
                pool[i][j] = {13'($random(seed)), 7'($random(seed)), 2'b00};
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // test 1, init sequence
        @(posedge clk);
        while (init) @(posedge clk);
        checks++;
        assert (init_ok) else begin
            $display("chip did not see precharge-all, two refreshes and load mode in order");
            errors++;
        end
        report("test 1 init");

        // test 2, one burst write then read per port
        for (int i = 0; i < 4; i++) begin
            req_q[i].push_back({1'b1, pool[i][0]});
            req_q[i].push_back({1'b0, pool[i][0]});
        end
        drain();
        report("test 2 write/read");

        // test 3, byte masks over a full write
        for (int i = 0; i < 4; i++) req_q[i].push_back({1'b1, pool[i][1]});
        drain();
        mask_mode = 1;
        for (int i = 0; i < 4; i++) req_q[i].push_back({1'b1, pool[i][1]});
        drain();
        mask_mode = 0;
        for (int i = 0; i < 4; i++) req_q[i].push_back({1'b0, pool[i][1]});
        drain();
        report("test 3 byte masks");

        // test 4, preload the pool then random concurrent traffic
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 8; j++) req_q[i].push_back({1'b1, pool[i][j]});
        end
        drain();
        mask_mode = 2;
        gate_on = 1'b1;
        for (int n = 0; n < 200; n++) begin
            p = $random(seed) & 3;
            req_q[p].push_back({1'($random(seed)), pool[p][$random(seed) & 7]});
        end
        drain();
        report("test 4 random traffic");

        // test 5, refresh pulses under traffic
        base = rfsh_count;
        for (int n = 0; n < 100; n++) begin
            p = $random(seed) & 3;
            req_q[p].push_back({1'($random(seed)), pool[p][$random(seed) & 7]});
        end
        for (int k = 1; k <= 3; k++) begin
            repeat (20) @(posedge clk);
            rfsh <= 1'b1;
            @(posedge clk);
            rfsh <= 1'b0;
            while (rfsh_count < base + k * sdram_pkg::RFSH_CNT) @(posedge clk);
        end
        drain();
        repeat (30) @(posedge clk);
        checks++;
        assert (rfsh_count == base + 3 * sdram_pkg::RFSH_CNT) else begin
            $display("[ERROR] %0t rfsh_count: expected %0d, got %0d",
                     $time, base + 3 * sdram_pkg::RFSH_CNT, rfsh_count);
            errors++;
        end
        report("test 5 refresh under traffic");

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
src/sdram_pkg.sv
src/sdram_bank_if.sv
src/sdram_init.sv
src/sdram_rfsh.sv
src/sdram_bank.sv
src/sdram_cmd_arbiter.sv
src/sdram_ctrl.sv
verif/sdram_chip_model.sv
verif/sdram_asserts.sv
verif/tb_sdram_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_ctrl \
    -f files.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^Test passed$"
